/* list.f */
design/hssl_pkg.sv
design/pkt_receiver.sv
design/hssl_reg_bank.sv
design/pkt_assembler.sv
design/pkt_router.sv
design/evt_hssl_top.sv
tb/tb_evt_hssl.sv

/* tb/tb_evt_hssl.sv */
`timescale 1ns/1ps

module tb_evt_hssl;
  import hssl_pkg::*;

  localparam int NUM_MREGS   = 4;
  localparam int NUM_RREGS   = 16;
  // directed config writes, rx packets and events plus the random run
  localparam int DIR_ITEMS   = 36;
  localparam int RAND_EVENTS = 200;
  localparam int WD_CYCLES   = 50 * (DIR_ITEMS + RAND_EVENTS) + 1000;

  logic        pl_clk0_buf_int;
  logic        rst_n;
  evt_t        evt_data;
  logic        evt_valid;
  logic        evt_ready;
  pkt_t        rx_pkt;
  logic        rx_valid;
  logic        rx_ready;
  routed_pkt_t tx_pkt;
  logic        tx_valid;
  logic        tx_ready;
  logic [31:0] cnt_periph;
  logic [31:0] cnt_cfg;
  logic [31:0] cnt_drop;

  // ----------------------------------------------------------------------
  // reference state written only by the stimulus tasks
  // ----------------------------------------------------------------------
  logic [31:0] m_mp_key;
  logic [31:0] m_fmsk [NUM_MREGS];
  logic [4:0]  m_fsft [NUM_MREGS];
  logic [31:0] m_rt_key [NUM_RREGS];
  logic [31:0] m_rt_mask [NUM_RREGS];
  logic        m_rt_en [NUM_RREGS];
  chan_t       m_rt_chan [NUM_RREGS];

  // expected tx stream and counters
  routed_pkt_t exp_q[$];
  routed_pkt_t exp_head;
  int          exp_count;
  logic [31:0] exp_cfg;
  logic [31:0] exp_periph;
  logic [31:0] exp_drop;

  // check enables for the assertions below
  logic        cnt_chk;
  logic        stop_chk;
  logic        stop_expected;
  logic        rand_ready = 1'b0;
  int          seed = 18090;
  string       test_name;

  evt_hssl_top #(
      .NUM_MREGS (NUM_MREGS)
    , .NUM_RREGS (NUM_RREGS)
  ) dut0 (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .evt_data        (evt_data)
    , .evt_valid       (evt_valid)
    , .evt_ready       (evt_ready)
    , .rx_pkt          (rx_pkt)
    , .rx_valid        (rx_valid)
    , .rx_ready        (rx_ready)
    , .tx_pkt          (tx_pkt)
    , .tx_valid        (tx_valid)
    , .tx_ready        (tx_ready)
    , .cnt_periph      (cnt_periph)
    , .cnt_cfg         (cnt_cfg)
    , .cnt_drop        (cnt_drop)
  );

  // 4 ns clock
  initial begin
    pl_clk0_buf_int = 1'b0;
    forever #2 pl_clk0_buf_int = ~pl_clk0_buf_int;
  end

  // link side readiness is random when enabled and moves 1 ns after the edge
  initial begin
    tx_ready = 1'b1;
    forever begin
      @(posedge pl_clk0_buf_int);
      #1;
      tx_ready = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge pl_clk0_buf_int);
    $display("timeout after %0d cycles in test %s", WD_CYCLES, test_name);
    end_with_failure();
  end

  // ----------------------------------------------------------------------
  // failure reporting
  // ----------------------------------------------------------------------
  task automatic end_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string what, input logic [95:0] exp,
                                 input logic [95:0] act);
    $display("CHECK FAILED test %s: %s expected %h actual %h", test_name, what, exp, act);
    end_with_failure();
  endtask

  task automatic report_error(input string what);
    $display("error in test %s: %s", test_name, what);
    end_with_failure();
  endtask

  // ----------------------------------------------------------------------
  // scoreboard
  // ----------------------------------------------------------------------
  task automatic push_expected(input routed_pkt_t r);
    exp_q.push_back(r);
    exp_head  = exp_q[0];
    exp_count = exp_q.size();
  endtask

  // retire the head on each tx handshake
  always @(posedge pl_clk0_buf_int) begin
    if (rst_n && tx_valid && tx_ready && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      exp_count = exp_q.size();
      if (exp_q.size() > 0) begin
        exp_head = exp_q[0];
      end
    end
  end

  reset_state_a: assert property (@(posedge pl_clk0_buf_int)
    $rose(rst_n) |-> !tx_valid && evt_ready && rx_ready)
    else report_mismatch("tx_valid evt_ready rx_ready", 96'(3'b011),
      96'({$sampled(tx_valid), $sampled(evt_ready), $sampled(rx_ready)}));

  rx_ready_a: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
    rx_ready)
    else report_error("rx_ready went low");

  tx_expected_a: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
    tx_valid && tx_ready |-> exp_count > 0)
    else report_error("packet delivered on tx with none expected");

  tx_value_a: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
    tx_valid && tx_ready && exp_count > 0 |-> tx_pkt == exp_head)
    else report_mismatch("tx packet", 96'($sampled(exp_head)), 96'($sampled(tx_pkt)));

  tx_hold_a: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_pkt))
    else report_error("tx packet changed or vanished while tx_ready was low");

  cnt_cfg_a: assert property (@(posedge pl_clk0_buf_int) cnt_chk |-> cnt_cfg == exp_cfg)
    else report_mismatch("cnt_cfg", 96'($sampled(exp_cfg)), 96'($sampled(cnt_cfg)));

  cnt_periph_a: assert property (@(posedge pl_clk0_buf_int)
    cnt_chk |-> cnt_periph == exp_periph)
    else report_mismatch("cnt_periph", 96'($sampled(exp_periph)), 96'($sampled(cnt_periph)));

  cnt_drop_a: assert property (@(posedge pl_clk0_buf_int) cnt_chk |-> cnt_drop == exp_drop)
    else report_mismatch("cnt_drop", 96'($sampled(exp_drop)), 96'($sampled(cnt_drop)));

  stop_a: assert property (@(posedge pl_clk0_buf_int) stop_chk |-> evt_ready == !stop_expected)
    else report_mismatch("evt_ready", 96'(!$sampled(stop_expected)), 96'($sampled(evt_ready)));

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  // base key ORed with each masked, right shifted event field
  function automatic logic [31:0] model_key(input evt_t e);
    logic [31:0] k;
    k = m_mp_key;
    for (int i = 0; i < NUM_MREGS; i++) begin
      k = k | ((e & m_fmsk[i]) >> m_fsft[i]);
    end
    return k;
  endfunction

  // returns {hit, chan} of the lowest enabled matching entry
  function automatic logic [3:0] model_route(input logic [31:0] k);
    for (int i = 0; i < NUM_RREGS; i++) begin
      if (m_rt_en[i] && ((k & m_rt_mask[i]) == m_rt_key[i])) begin
        return {1'b1, m_rt_chan[i]};
      end
    end
    return 4'b0;
  endfunction

  // ----------------------------------------------------------------------
  // stimulus tasks start and end 1 ns after a rising edge
  // ----------------------------------------------------------------------
  task automatic send_rx(input pkt_t p);
    rx_pkt   = p;
    rx_valid = 1'b1;
    do @(posedge pl_clk0_buf_int); while (!rx_ready);
    #1;
    rx_valid = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    pkt_t p;
    p.hdr  = 8'h00;
    p.key  = {CFG_PREFIX, addr};
    p.data = data;
    send_rx(p);
    exp_cfg++;
  endtask

  task automatic send_periph(input logic [31:0] key, input logic [31:0] data);
    pkt_t p;
    p.hdr  = 8'h40;
    p.key  = key;
    p.data = data;
    send_rx(p);
    exp_periph++;
  endtask

  task automatic set_field(input int i, input logic [31:0] mask, input logic [4:0] sft);
    write_reg(ADDR_FMSK_BASE + 8'(i), mask);
    write_reg(ADDR_FSFT_BASE + 8'(i), 32'(sft));
    m_fmsk[i] = mask;
    m_fsft[i] = sft;
  endtask

  task automatic set_route(input int i, input logic [31:0] key, input logic [31:0] mask,
                           input logic en, input chan_t ch);
    write_reg(ADDR_RT_KEY_BASE + 8'(i), key);
    write_reg(ADDR_RT_MASK_BASE + 8'(i), mask);
    write_reg(ADDR_RT_ROUTE_BASE + 8'(i), {en, 28'd0, ch});
    m_rt_key[i]  = key;
    m_rt_mask[i] = mask;
    m_rt_en[i]   = en;
    m_rt_chan[i] = ch;
  endtask

  // config write lands two edges after acceptance
  task automatic settle();
    repeat (3) @(posedge pl_clk0_buf_int);
    #1;
  endtask

  task automatic send_event(input evt_t e);
    logic [31:0] k;
    logic [3:0]  rt_res;
    routed_pkt_t r;
    k      = model_key(e);
    rt_res = model_route(k);
    if (rt_res[3]) begin
      r.pkt.hdr  = HDR_MC;
      r.pkt.key  = k;
      r.pkt.data = e;
      r.chan     = rt_res[2:0];
      push_expected(r);
    end else begin
      exp_drop++;
    end
    evt_data  = e;
    evt_valid = 1'b1;
    do @(posedge pl_clk0_buf_int); while (!evt_ready);
    #1;
    evt_valid = 1'b0;
  endtask

  // misses need one more edge to reach the drop counter
  task automatic drain();
    while (exp_count != 0) @(posedge pl_clk0_buf_int);
    repeat (4) @(posedge pl_clk0_buf_int);
    #1;
  endtask

  task automatic check_counters();
    drain();
    cnt_chk = 1'b1;
    @(posedge pl_clk0_buf_int);
    #1;
    cnt_chk = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    rst_n         = 1'b0;
    evt_data      = '0;
    evt_valid     = 1'b0;
    rx_pkt        = '0;
    rx_valid      = 1'b0;
    cnt_chk       = 1'b0;
    stop_chk      = 1'b0;
    stop_expected = 1'b0;
    exp_head      = '0;
    exp_count     = 0;
    exp_cfg       = '0;
    exp_periph    = '0;
    exp_drop      = '0;
    m_mp_key      = '0;
    test_name     = "reset";
    for (int i = 0; i < NUM_MREGS; i++) begin
      m_fmsk[i] = '0;
      m_fsft[i] = '0;
    end
    for (int i = 0; i < NUM_RREGS; i++) begin
      m_rt_key[i]  = '0;
      m_rt_mask[i] = '0;
      m_rt_en[i]   = 1'b0;
      m_rt_chan[i] = '0;
    end
    repeat (4) @(posedge pl_clk0_buf_int);
    #1;
    rst_n = 1'b1;
    @(posedge pl_clk0_buf_int);
    #1;
    check_counters();

    // mapper takes low byte, middle byte and top nibble into bits 15:12
    test_name = "mapping";
    write_reg(ADDR_MP_KEY, 32'h1234_0000);
    m_mp_key = 32'h1234_0000;
    set_field(0, 32'h0000_00FF, 5'd0);
    set_field(1, 32'h0000_FF00, 5'd4);
    set_field(2, 32'h00FF_0000, 5'd16);
    set_field(3, 32'hF000_0000, 5'd16);
    // entry 0 shadows entry 1 for some keys and entry 5 stays disabled
    set_route(0, 32'h1234_0005, 32'hFFFF_F00F, 1'b1, 3'd7);
    set_route(1, 32'h1234_0000, 32'hFFFF_F000, 1'b1, 3'd5);
    set_route(3, 32'h1234_8000, 32'hFFFF_8000, 1'b1, 3'd2);
    set_route(5, 32'h1234_1000, 32'hFFFF_F000, 1'b0, 3'd4);
    settle();
    send_event(32'h0000_0005);
    send_event(32'h0000_1234);
    send_event(32'h8012_3456);
    send_event(32'h0AB0_0C01);
    check_counters();

    test_name = "drop";
    send_event(32'h1000_0001);
    send_event(32'h3000_0000);
    send_event(32'h0000_00F0);
    check_counters();

    test_name = "backpressure";
    rand_ready = 1'b1;
    for (int n = 0; n < RAND_EVENTS; n++) begin
      send_event(evt_t'($random(seed)));
    end
    check_counters();
    rand_ready = 1'b0;

    test_name = "stop";
    write_reg(ADDR_CTRL, 32'h0000_0001);
    settle();
    stop_expected = 1'b1;
    stop_chk      = 1'b1;
    repeat (8) @(posedge pl_clk0_buf_int);
    #1;
    stop_chk = 1'b0;
    write_reg(ADDR_CTRL, 32'h0000_0000);
    settle();
    stop_expected = 1'b0;
    stop_chk      = 1'b1;
    repeat (2) @(posedge pl_clk0_buf_int);
    #1;
    stop_chk = 1'b0;
    send_event(32'h0000_0042);
    check_counters();

    // near-miss prefix and plain keys that must not touch any register
    test_name = "peripheral";
    send_periph({24'hC0F1C1, ADDR_MP_KEY}, 32'hFFFF_FFFF);
    send_periph({24'h000000, ADDR_RT_ROUTE_BASE + 8'd5}, 32'h8000_0004);
    send_periph(32'hDEAD_BEEF, 32'h0000_0001);
    settle();
    send_event(32'h1000_0001);
    send_event(32'h0000_0077);
    check_counters();

    if (exp_count != 0) begin
      $display("%0d expected packets never appeared on tx", exp_count);
      end_with_failure();
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

/* design/evt_hssl_top.sv */
`timescale 1ns/1ps

module evt_hssl_top #(
    parameter int NUM_MREGS = 4
  , parameter int NUM_RREGS = 16
) (
    input  logic                  pl_clk0_buf_int
  , input  logic                  rst_n

    // sensor events
  , input  hssl_pkg::evt_t        evt_data
  , input  logic                  evt_valid
  , output logic                  evt_ready

    // packets from the link
  , input  hssl_pkg::pkt_t        rx_pkt
  , input  logic                  rx_valid
  , output logic                  rx_ready

    // routed packets to the link
  , output hssl_pkg::routed_pkt_t tx_pkt
  , output logic                  tx_valid
  , input  logic                  tx_ready

    // diagnostic counters
  , output logic [31:0]           cnt_periph
  , output logic [31:0]           cnt_cfg
  , output logic [31:0]           cnt_drop
);
  import hssl_pkg::*;

  // ----------------------------------------------------------------------
  // internal wires
  // ----------------------------------------------------------------------
  // receiver to register bank
  cfg_wr_t     cfg_wr;
  logic        cfg_we;
  logic        periph_seen;
  logic        cfg_seen;

  // register bank outputs
  logic        stop;
  logic [31:0] mp_key;
  logic [31:0] fmsk [NUM_MREGS];
  fsft_t       fsft [NUM_MREGS];
  route_cfg_t  rt   [NUM_RREGS];

  // assembler to router
  pkt_t        pkt;
  logic        pkt_valid;
  logic        pkt_ready;

  // router miss pulse
  logic        drop;

  // ----------------------------------------------------------------------
  // link input and configuration
  // ----------------------------------------------------------------------
  pkt_receiver prx (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .rx_pkt          (rx_pkt)
    , .rx_valid        (rx_valid)
    , .rx_ready        (rx_ready)
    , .cfg_wr          (cfg_wr)
    , .cfg_we          (cfg_we)
    , .periph_seen     (periph_seen)
    , .cfg_seen        (cfg_seen)
  );

  hssl_reg_bank #(
      .NUM_MREGS (NUM_MREGS)
    , .NUM_RREGS (NUM_RREGS)
  ) rb (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .cfg_wr          (cfg_wr)
    , .cfg_we          (cfg_we)
    , .periph_seen     (periph_seen)
    , .cfg_seen        (cfg_seen)
    , .drop            (drop)
    , .stop            (stop)
    , .mp_key          (mp_key)
    , .fmsk            (fmsk)
    , .fsft            (fsft)
    , .rt              (rt)
    , .cnt_periph      (cnt_periph)
    , .cnt_cfg         (cnt_cfg)
    , .cnt_drop        (cnt_drop)
  );

  // ----------------------------------------------------------------------
  // event to packet path
  // ----------------------------------------------------------------------
  pkt_assembler #(
      .NUM_MREGS (NUM_MREGS)
  ) pa (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .stop            (stop)
    , .mp_key          (mp_key)
    , .fmsk            (fmsk)
    , .fsft            (fsft)
    , .evt_data        (evt_data)
    , .evt_valid       (evt_valid)
    , .evt_ready       (evt_ready)
    , .pkt             (pkt)
    , .pkt_valid       (pkt_valid)
    , .pkt_ready       (pkt_ready)
  );

  pkt_router #(
      .NUM_RREGS (NUM_RREGS)
  ) pr (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .rt              (rt)
    , .pkt             (pkt)
    , .pkt_valid       (pkt_valid)
    , .pkt_ready       (pkt_ready)
    , .tx_pkt          (tx_pkt)
    , .tx_valid        (tx_valid)
    , .tx_ready        (tx_ready)
    , .drop            (drop)
  );

endmodule

/* design/pkt_router.sv */
`timescale 1ns/1ps

module pkt_router #(
    parameter int NUM_RREGS = 16
) (
    input  logic                  pl_clk0_buf_int
  , input  logic                  rst_n

    // routing table
  , input  hssl_pkg::route_cfg_t  rt [NUM_RREGS]

    // assembled packets
  , input  hssl_pkg::pkt_t        pkt
  , input  logic                  pkt_valid
  , output logic                  pkt_ready

    // routed packets
  , output hssl_pkg::routed_pkt_t tx_pkt
  , output logic                  tx_valid
  , input  logic                  tx_ready

    // unrouted packet pulse
  , output logic                  drop
);
  import hssl_pkg::*;

  // table lookup result
  logic  hit;
  chan_t hit_chan;

  // input transfer
  logic  take;

  // ----------------------------------------------------------------------
  // table match
  // ----------------------------------------------------------------------
  // scan from the top so the lowest matching entry wins
  always_comb begin
    hit      = 1'b0;
    hit_chan = '0;
    for (int i = NUM_RREGS - 1; i >= 0; i--) begin
      if (rt[i].en && ((pkt.key & rt[i].mask) == rt[i].key)) begin
        hit      = 1'b1;
        hit_chan = rt[i].chan;
      end
    end
  end

  // ----------------------------------------------------------------------
  // handshake
  // ----------------------------------------------------------------------
  // misses are accepted too, they just never reach tx
  assign pkt_ready = !tx_valid || tx_ready;
  assign take      = pkt_valid && pkt_ready;

  // ----------------------------------------------------------------------
  // output register
  // ----------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n) begin
    if (!rst_n) begin
      tx_valid <= 1'b0;
    end else if (take) begin
      // a miss leaves the register empty
      tx_valid <= hit;
    end else if (tx_ready) begin
      tx_valid <= 1'b0;
    end
  end

  always_ff @(posedge pl_clk0_buf_int) begin
    if (take && hit) begin
      tx_pkt.pkt  <= pkt;
      tx_pkt.chan <= hit_chan;
    end
  end

  // ----------------------------------------------------------------------
  // drop pulse
  // ----------------------------------------------------------------------
  // one cycle per unrouted packet, counted by the bank next edge
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n) begin
    if (!rst_n) begin
      drop <= 1'b0;
    end else begin
      drop <= take && !hit;
    end
  end

  // link side may stall for any number of cycles
  tx_hold_a: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_pkt))
    else $error("tx packet changed while waiting for tx_ready");

endmodule

/* design/pkt_assembler.sv */
`timescale 1ns/1ps

module pkt_assembler #(
    parameter int NUM_MREGS = 4
) (
    input  logic            pl_clk0_buf_int
  , input  logic            rst_n

    // mapper registers
  , input  logic            stop
  , input  logic [31:0]     mp_key
  , input  logic [31:0]     fmsk [NUM_MREGS]
  , input  hssl_pkg::fsft_t fsft [NUM_MREGS]

    // incoming events
  , input  hssl_pkg::evt_t  evt_data
  , input  logic            evt_valid
  , output logic            evt_ready

    // assembled packets
  , output hssl_pkg::pkt_t  pkt
  , output logic            pkt_valid
  , input  logic            pkt_ready
);
  import hssl_pkg::*;

  // mapped key of the current event
  logic [31:0] key;
  logic        take;

  // ----------------------------------------------------------------------
  // field mapping
  // ----------------------------------------------------------------------
  // base key ORed with every masked, shifted field
  always_comb begin
    key = mp_key;
    for (int i = 0; i < NUM_MREGS; i++) begin
      key = key | ((evt_data & fmsk[i]) >> fsft[i]);
    end
  end

  // ----------------------------------------------------------------------
  // handshake
  // ----------------------------------------------------------------------
  // stop blocks new events, output still drains
  assign evt_ready = !stop && (!pkt_valid || pkt_ready);
  assign take      = evt_valid && evt_ready;

  // ----------------------------------------------------------------------
  // output register
  // ----------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n) begin
    if (!rst_n) begin
      pkt_valid <= 1'b0;
    end else if (take) begin
      pkt_valid <= 1'b1;
    end else if (pkt_ready) begin
      pkt_valid <= 1'b0;
    end
  end

  // payload carries the raw event
  always_ff @(posedge pl_clk0_buf_int) begin
    if (take) begin
      pkt.hdr  <= HDR_MC;
      pkt.key  <= key;
      pkt.data <= evt_data;
    end
  end

  // held packet must not change while the router stalls
  pkt_hold_a: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
    pkt_valid && !pkt_ready |=> pkt_valid && $stable(pkt))
    else $error("assembler output changed under back-pressure");

endmodule

/* design/hssl_reg_bank.sv */
`timescale 1ns/1ps

module hssl_reg_bank #(
    parameter int NUM_MREGS = 4
  , parameter int NUM_RREGS = 16
) (
    input  logic                 pl_clk0_buf_int
  , input  logic                 rst_n

    // writes from the packet receiver
  , input  hssl_pkg::cfg_wr_t    cfg_wr
  , input  logic                 cfg_we

    // counter events
  , input  logic                 periph_seen
  , input  logic                 cfg_seen
  , input  logic                 drop

    // control and mapper registers
  , output logic                 stop
  , output logic [31:0]          mp_key
  , output logic [31:0]          fmsk [NUM_MREGS]
  , output hssl_pkg::fsft_t      fsft [NUM_MREGS]

    // routing table
  , output hssl_pkg::route_cfg_t rt   [NUM_RREGS]

    // diagnostic counters
  , output logic [31:0]          cnt_periph
  , output logic [31:0]          cnt_cfg
  , output logic [31:0]          cnt_drop
);
  import hssl_pkg::*;

  // ----------------------------------------------------------------------
  // register writes
  // ----------------------------------------------------------------------
  // unmapped addresses match nothing and fall through
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n) begin
    if (!rst_n) begin
      stop   <= 1'b0;
      mp_key <= '0;
      for (int i = 0; i < NUM_MREGS; i++) begin
        fmsk[i] <= '0;
        fsft[i] <= '0;
      end
      // all routes disabled
      for (int j = 0; j < NUM_RREGS; j++) begin
        rt[j] <= '0;
      end
    end else if (cfg_we) begin
      if (cfg_wr.addr == ADDR_CTRL) begin
        stop <= cfg_wr.data[0];
      end
      if (cfg_wr.addr == ADDR_MP_KEY) begin
        mp_key <= cfg_wr.data;
      end
      // mapper field masks and shifts
      for (int i = 0; i < NUM_MREGS; i++) begin
        if (cfg_wr.addr == ADDR_FMSK_BASE + 8'(i)) begin
          fmsk[i] <= cfg_wr.data;
        end
        if (cfg_wr.addr == ADDR_FSFT_BASE + 8'(i)) begin
          fsft[i] <= cfg_wr.data[4:0];
        end
      end
      // routing entries
      for (int j = 0; j < NUM_RREGS; j++) begin
        if (cfg_wr.addr == ADDR_RT_KEY_BASE + 8'(j)) begin
          rt[j].key <= cfg_wr.data;
        end
        if (cfg_wr.addr == ADDR_RT_MASK_BASE + 8'(j)) begin
          rt[j].mask <= cfg_wr.data;
        end
        // enable in bit 31, channel in low bits
        if (cfg_wr.addr == ADDR_RT_ROUTE_BASE + 8'(j)) begin
          rt[j].en   <= cfg_wr.data[31];
          rt[j].chan <= cfg_wr.data[2:0];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // counters
  // ----------------------------------------------------------------------
  // free running, wrap at 2^32
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n) begin
    if (!rst_n) begin
      cnt_periph <= '0;
      cnt_cfg    <= '0;
      cnt_drop   <= '0;
    end else begin
      cnt_periph <= cnt_periph + 32'(periph_seen);
      cnt_cfg    <= cnt_cfg + 32'(cfg_seen);
      cnt_drop   <= cnt_drop + 32'(drop);
    end
  end

  // shift values above 31 would be truncated silently
  fsft_range_a: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
    cfg_we && (cfg_wr.addr >= ADDR_FSFT_BASE)
      && (cfg_wr.addr < ADDR_FSFT_BASE + 8'(NUM_MREGS))
    |-> (cfg_wr.data < 32'd32))
    else $error("field shift written with value %0d", cfg_wr.data);

endmodule

/* design/pkt_receiver.sv */
`timescale 1ns/1ps

module pkt_receiver (
    input  logic              pl_clk0_buf_int
  , input  logic              rst_n

    // packets from the link
  , input  hssl_pkg::pkt_t    rx_pkt
  , input  logic              rx_valid
  , output logic              rx_ready

    // register write towards the bank
  , output hssl_pkg::cfg_wr_t cfg_wr
  , output logic              cfg_we

    // counter pulses
  , output logic              periph_seen
  , output logic              cfg_seen
);
  import hssl_pkg::*;

  // capture stage
  rx_key_u     key_q;
  logic [31:0] data_q;
  logic        in_vld_q;

  // decode of the captured key
  logic        is_cfg;

  // never back-pressures the link
  assign rx_ready = 1'b1;

  // ----------------------------------------------------------------------
  // stage 1 capture
  // ----------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n) begin
    if (!rst_n) begin
      in_vld_q <= 1'b0;
    end else begin
      in_vld_q <= rx_valid && rx_ready;
    end
  end

  // key and payload only
  always_ff @(posedge pl_clk0_buf_int) begin
    if (rx_valid && rx_ready) begin
      key_q.raw <= rx_pkt.key;
      data_q    <= rx_pkt.data;
    end
  end

  // config packets carry the magic prefix in the top 24 key bits
  assign is_cfg = (key_q.cfg.prefix == CFG_PREFIX);

  // ----------------------------------------------------------------------
  // stage 2 steer
  // ----------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n) begin
    if (!rst_n) begin
      cfg_we      <= 1'b0;
      cfg_seen    <= 1'b0;
      periph_seen <= 1'b0;
    end else begin
      cfg_we      <= in_vld_q && is_cfg;
      cfg_seen    <= in_vld_q && is_cfg;
      // no peripheral output so count and discard
      periph_seen <= in_vld_q && !is_cfg;
    end
  end

  // address from the config view, data from the payload
  always_ff @(posedge pl_clk0_buf_int) begin
    if (in_vld_q && is_cfg) begin
      cfg_wr.addr <= key_q.cfg.addr;
      cfg_wr.data <= data_q;
    end
  end

  // accepted packet goes exactly one way, judged from the raw key bits
  steer_excl_a: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
    rx_valid && rx_ready |=> ##1
      (cfg_we == ($past(rx_pkt.key[31:8], 2) == CFG_PREFIX))
      && (cfg_we != periph_seen)
      && (!cfg_we || cfg_wr == {$past(rx_pkt.key[7:0], 2), $past(rx_pkt.data, 2)}))
    else $error("packet steered wrongly or both to config and peripheral");

endmodule

/* design/hssl_pkg.sv */
package hssl_pkg;

  // ----------------------------------------------------------------------
  // basic words
  // ----------------------------------------------------------------------
  // raw sensor event as it arrives on the event stream
  typedef logic [31:0] evt_t;

  // output channel index
  typedef logic [2:0] chan_t;

  // field shift amount, one per mapper field
  typedef logic [4:0] fsft_t;

  // ----------------------------------------------------------------------
  // packets
  // ----------------------------------------------------------------------
  // link packet, 72 bits
  typedef struct packed {
    logic [7:0]  hdr;
    logic [31:0] key;
    logic [31:0] data;
  } pkt_t;

  // packet plus the channel picked by the routing table
  typedef struct packed {
    pkt_t  pkt;
    chan_t chan;
  } routed_pkt_t;

  // key of a configuration packet
  typedef struct packed {
    logic [23:0] prefix;
    logic [7:0]  addr;
  } cfg_key_t;

  // received key, seen either as a plain key or as a config address
  typedef union packed {
    logic [31:0] raw;
    cfg_key_t    cfg;
  } rx_key_u;

  // ----------------------------------------------------------------------
  // configuration
  // ----------------------------------------------------------------------
  // one register write from the link
  typedef struct packed {
    logic [7:0]  addr;
    logic [31:0] data;
  } cfg_wr_t;

  // one routing table entry
  typedef struct packed {
    logic [31:0] key;
    logic [31:0] mask;
    logic        en;
    chan_t       chan;
  } route_cfg_t;

  // key prefix of config packets
  localparam logic [23:0] CFG_PREFIX = 24'hC0F1C0;

  // header byte of assembled multicast packets
  localparam logic [7:0] HDR_MC = 8'h02;

  // register map
  localparam logic [7:0] ADDR_CTRL          = 8'h00;
  localparam logic [7:0] ADDR_MP_KEY        = 8'h01;
  localparam logic [7:0] ADDR_FMSK_BASE     = 8'h04;
  localparam logic [7:0] ADDR_FSFT_BASE     = 8'h08;
  localparam logic [7:0] ADDR_RT_KEY_BASE   = 8'h10;
  localparam logic [7:0] ADDR_RT_MASK_BASE  = 8'h20;
  localparam logic [7:0] ADDR_RT_ROUTE_BASE = 8'h30;

endpackage
